//--- Makefile
VERILATOR  ?= verilator
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
TOP        := l1i_cache_tb
FILELIST   := sources.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := ALL TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

# The simulator output is kept in a log and the verdict is taken from it.
run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sources.f
src/l1i_geom_pkg.sv
src/l1i_bus_pkg.sv
src/l1i_data_array.sv
src/l1i_tag_array.sv
src/l1i_controller.sv
src/l1i_cache.sv
verification/l2_model.sv
verification/l1i_cache_tb.sv

//--- src/l1i_bus_pkg.sv
package l1i_bus_pkg;

    // Fetch request from the core.
    typedef struct packed {
        l1i_geom_pkg::addr_t addr;
    } fetch_req_t;

    // Fetch response to the core.
    typedef struct packed {
        l1i_geom_pkg::word_t word;
    } fetch_resp_t;

    // Refill request to the level-two cache.
    // The offset bits of line_addr are always zero.
    typedef struct packed {
        l1i_geom_pkg::addr_t line_addr;
    } refill_req_t;

    // Refill response carrying one whole line.
    typedef struct packed {
        l1i_geom_pkg::line_t line;
    } refill_resp_t;

endpackage

//--- src/l1i_cache.sv
`timescale 1ns/1ns

module l1i_cache (
    input  logic                       clk,
    input  logic                       nrst,
    input  logic                       req_valid,
    output logic                       req_ready,
    input  l1i_bus_pkg::fetch_req_t    req,
    output logic                       resp_valid,
    input  logic                       resp_ready,
    output l1i_bus_pkg::fetch_resp_t   resp,
    input  logic                       flush_valid,
    output logic                       flush_ready,
    output logic                       l2_req_valid,
    input  logic                       l2_req_ready,
    output l1i_bus_pkg::refill_req_t   l2_req,
    input  logic                       l2_resp_valid,
    output logic                       l2_resp_ready,
    input  l1i_bus_pkg::refill_resp_t  l2_resp
);

    l1i_geom_pkg::index_t     lookup_index;
    l1i_geom_pkg::word_sel_t  lookup_word_sel;
    logic                     refill_en;
    l1i_geom_pkg::tag_t       refill_tag;
    logic                     flush_en;
    l1i_geom_pkg::tag_t       hit_tag;
    logic                     hit_valid;
    l1i_geom_pkg::word_t      rd_word;

    l1i_controller u_controller (
        .clk             (clk),
        .nrst            (nrst),
        .req_valid       (req_valid),
        .req_ready       (req_ready),
        .req             (req),
        .resp_valid      (resp_valid),
        .resp_ready      (resp_ready),
        .resp            (resp),
        .flush_valid     (flush_valid),
        .flush_ready     (flush_ready),
        .l2_req_valid    (l2_req_valid),
        .l2_req_ready    (l2_req_ready),
        .l2_req          (l2_req),
        .l2_resp_valid   (l2_resp_valid),
        .l2_resp_ready   (l2_resp_ready),
        .lookup_index    (lookup_index),
        .lookup_word_sel (lookup_word_sel),
        .refill_en       (refill_en),
        .refill_tag      (refill_tag),
        .flush_en        (flush_en),
        .hit_tag         (hit_tag),
        .hit_valid       (hit_valid),
        .rd_word         (rd_word)
    );

    l1i_tag_array u_tag_array (
        .clk        (clk),
        .nrst       (nrst),
        .index      (lookup_index),
        .refill_en  (refill_en),
        .refill_tag (refill_tag),
        .flush_en   (flush_en),
        .hit_tag    (hit_tag),
        .hit_valid  (hit_valid)
    );

    l1i_data_array u_data_array (
        .clk         (clk),
        .nrst        (nrst),
        .index       (lookup_index),
        .word_sel    (lookup_word_sel),
        .refill_en   (refill_en),
        .refill_line (l2_resp.line),
        .rd_word     (rd_word)
    );

endmodule

//--- src/l1i_controller.sv
`timescale 1ns/1ns

module l1i_controller (
    input  logic                      clk,
    input  logic                      nrst,
    input  logic                      req_valid,
    output logic                      req_ready,
    input  l1i_bus_pkg::fetch_req_t   req,
    output logic                      resp_valid,
    input  logic                      resp_ready,
    output l1i_bus_pkg::fetch_resp_t  resp,
    input  logic                      flush_valid,
    output logic                      flush_ready,
    output logic                      l2_req_valid,
    input  logic                      l2_req_ready,
    output l1i_bus_pkg::refill_req_t  l2_req,
    input  logic                      l2_resp_valid,
    output logic                      l2_resp_ready,
    output l1i_geom_pkg::index_t      lookup_index,
    output l1i_geom_pkg::word_sel_t   lookup_word_sel,
    output logic                      refill_en,
    output l1i_geom_pkg::tag_t        refill_tag,
    output logic                      flush_en,
    input  l1i_geom_pkg::tag_t        hit_tag,
    input  logic                      hit_valid,
    input  l1i_geom_pkg::word_t       rd_word
);

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        REFILL_REQ,
        REFILL_WAIT,
        REREAD,
        RESPOND
    } state_t;

    state_t               state_q;
    state_t               state_d;
    l1i_geom_pkg::addr_t  addr_q;
    l1i_geom_pkg::addr_t  lookup_addr;
    l1i_geom_pkg::word_t  resp_q;
    l1i_geom_pkg::tag_t   addr_tag;
    logic                 hit;
    logic                 fetch_fire;

    // Flush wins over a fetch, so the core sees no req_ready while it waits.
    assign flush_ready = (state_q == IDLE);
    assign req_ready   = (state_q == IDLE) && !flush_valid;
    assign flush_en    = flush_ready && flush_valid;
    assign fetch_fire  = req_ready && req_valid;

    // In IDLE the arrays look at the incoming address so that the result is
    // ready in LOOKUP. Afterwards they keep reading the latched address.
    assign lookup_addr     = (state_q == IDLE) ? req.addr : addr_q;
    assign lookup_index    = lookup_addr[l1i_geom_pkg::OFFSET_W +: l1i_geom_pkg::INDEX_W];
    assign lookup_word_sel = lookup_addr[l1i_geom_pkg::OFFSET_W-1 -: l1i_geom_pkg::WORD_SEL_W];

    assign addr_tag = addr_q[l1i_geom_pkg::ADDR_W-1 -: l1i_geom_pkg::TAG_W];
    assign hit      = hit_valid && (hit_tag == addr_tag);

    assign l2_req_valid     = (state_q == REFILL_REQ);
    assign l2_req.line_addr = {addr_q[l1i_geom_pkg::ADDR_W-1:l1i_geom_pkg::OFFSET_W],
                               {l1i_geom_pkg::OFFSET_W{1'b0}}};
    assign l2_resp_ready    = (state_q == REFILL_WAIT);
    assign refill_en        = l2_resp_ready && l2_resp_valid;
    assign refill_tag       = addr_tag;

    // A hit answers straight from the data array in LOOKUP. Under
    // back-pressure the word is parked in resp_q.
    assign resp_valid = ((state_q == LOOKUP) && hit) || (state_q == RESPOND);
    assign resp.word  = (state_q == LOOKUP) ? rd_word : resp_q;

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            IDLE:
            begin
                if (fetch_fire)
                begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP:
            begin
                if (!hit)
                begin
                    state_d = REFILL_REQ;
                end
                else if (resp_ready)
                begin
                    state_d = IDLE;
                end
                else
                begin
                    state_d = RESPOND;
                end
            end
            REFILL_REQ:
            begin
                if (l2_req_ready)
                begin
                    state_d = REFILL_WAIT;
                end
            end
            REFILL_WAIT:
            begin
                if (l2_resp_valid)
                begin
                    state_d = REREAD;
                end
            end
            // The arrays captured the old line at the refill edge, so the
            // refilled set is read once more before LOOKUP hits on it.
            REREAD:
            begin
                state_d = LOOKUP;
            end
            RESPOND:
            begin
                if (resp_ready)
                begin
                    state_d = IDLE;
                end
            end
            default:
            begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            state_q <= IDLE;
        end
        else
        begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk)
    begin
        if (fetch_fire)
        begin
            addr_q <= req.addr;
        end
        if ((state_q == LOOKUP) && hit && !resp_ready)
        begin
            resp_q <= rd_word;
        end
    end

    a_resp_stable: assert property (
        @(posedge clk) disable iff (!nrst)
        (resp_valid && !resp_ready) |=> (resp_valid && $stable(resp))
    );

    a_l2_req_held: assert property (
        @(posedge clk) disable iff (!nrst)
        (l2_req_valid && !l2_req_ready) |=> (l2_req_valid && $stable(l2_req))
    );

endmodule

//--- src/l1i_data_array.sv
`timescale 1ns/1ns

module l1i_data_array (
    input  logic                     clk,
    input  logic                     nrst,
    input  l1i_geom_pkg::index_t     index,
    input  l1i_geom_pkg::word_sel_t  word_sel,
    input  logic                     refill_en,
    input  l1i_geom_pkg::line_t      refill_line,
    output l1i_geom_pkg::word_t      rd_word
);

    l1i_geom_pkg::line_t mem [l1i_geom_pkg::NUM_SETS];

    // The word is picked from the line before the register, so a read
    // result shows up one cycle after the index.
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            rd_word <= '0;
        end
        else
        begin
            rd_word <= mem[index][word_sel * l1i_geom_pkg::WORD_W +: l1i_geom_pkg::WORD_W];
        end
    end

    // A refill replaces the whole line at once.
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            for (int i = 0; i < l1i_geom_pkg::NUM_SETS; i++)
            begin
                mem[i] <= '0;
            end
        end
        else if (refill_en)
        begin
            mem[index] <= refill_line;
        end
    end

    // A refill into an unknown set would corrupt an unpredictable line.
    a_refill_index_known: assert property (
        @(posedge clk) disable iff (!nrst)
        refill_en |-> !$isunknown(index)
    );

endmodule

//--- src/l1i_geom_pkg.sv
package l1i_geom_pkg;

    // Direct-mapped geometry with 64 sets of 64-byte lines.
    localparam int ADDR_W     = 32;
    localparam int WORD_W     = 32;
    localparam int LINE_W     = 512;
    localparam int NUM_SETS   = 64;
    localparam int OFFSET_W   = $clog2(LINE_W / 8);
    localparam int INDEX_W    = $clog2(NUM_SETS);
    localparam int TAG_W      = ADDR_W - INDEX_W - OFFSET_W;
    localparam int WORD_SEL_W = $clog2(LINE_W / WORD_W);

    // Byte address as issued by the core.
    typedef logic [ADDR_W-1:0] addr_t;

    // One instruction word.
    typedef logic [WORD_W-1:0] word_t;

    // One full cache line as moved on a refill.
    typedef logic [LINE_W-1:0] line_t;

    // Set index, the address bits just above the line offset.
    typedef logic [INDEX_W-1:0] index_t;

    // Tag, the address bits above the index.
    typedef logic [TAG_W-1:0] tag_t;

    // Word position inside a line, address bits 5 to 2.
    typedef logic [WORD_SEL_W-1:0] word_sel_t;

endpackage

//--- src/l1i_tag_array.sv
`timescale 1ns/1ns

module l1i_tag_array (
    input  logic                  clk,
    input  logic                  nrst,
    input  l1i_geom_pkg::index_t  index,
    input  logic                  refill_en,
    input  l1i_geom_pkg::tag_t    refill_tag,
    input  logic                  flush_en,
    output l1i_geom_pkg::tag_t    hit_tag,
    output logic                  hit_valid
);

    l1i_geom_pkg::tag_t                 tags [l1i_geom_pkg::NUM_SETS];
    logic [l1i_geom_pkg::NUM_SETS-1:0]  valid;

    // Registered lookup of the presented set.
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            hit_tag   <= '0;
            hit_valid <= 1'b0;
        end
        else
        begin
            hit_tag   <= tags[index];
            hit_valid <= valid[index];
        end
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            for (int i = 0; i < l1i_geom_pkg::NUM_SETS; i++)
            begin
                tags[i] <= '0;
            end
        end
        else if (refill_en)
        begin
            tags[index] <= refill_tag;
        end
    end

    // Flush drops every line in one cycle. Tags are left as they are.
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            valid <= '0;
        end
        else if (flush_en)
        begin
            valid <= '0;
        end
        else if (refill_en)
        begin
            valid[index] <= 1'b1;
        end
    end

    // The controller only flushes from IDLE and only refills from REFILL_WAIT.
    a_no_refill_during_flush: assert property (
        @(posedge clk) disable iff (!nrst)
        !(refill_en && flush_en)
    );

endmodule

//--- verification/l1i_cache_tb.sv
`timescale 1ns/1ns

module l1i_cache_tb;

    localparam int NUM_STEPS      = 14;
    localparam int TIMEOUT_CYCLES = 40 * NUM_STEPS + 20;

    typedef struct packed {
        logic                 is_flush;
        l1i_geom_pkg::addr_t  addr;
        l1i_geom_pkg::word_t  exp_word;
        logic                 exp_refill;
        int                   stall;
    } step_t;

    logic                       clk;
    logic                       nrst;
    logic                       req_valid;
    logic                       req_ready;
    l1i_bus_pkg::fetch_req_t    req;
    logic                       resp_valid;
    logic                       resp_ready;
    l1i_bus_pkg::fetch_resp_t   resp;
    logic                       flush_valid;
    logic                       flush_ready;
    logic                       l2_req_valid;
    logic                       l2_req_ready;
    l1i_bus_pkg::refill_req_t   l2_req;
    logic                       l2_resp_valid;
    logic                       l2_resp_ready;
    l1i_bus_pkg::refill_resp_t  l2_resp;
    int                         refill_count;
    int                         cycle_count;

    // Sets 1 and 62 are used, and tags 0x1 and 0x23 conflict in set 1.
    step_t steps [NUM_STEPS] = '{
        '{1'b0, 32'h0000_1040, 32'h5A5A_1040, 1'b1, 0},
        '{1'b0, 32'h0000_1044, 32'h5A5A_1044, 1'b0, 0},
        '{1'b0, 32'h0000_107C, 32'h5A5A_107C, 1'b0, 0},
        '{1'b0, 32'h0000_104E, 32'h5A5A_104C, 1'b0, 0},
        '{1'b0, 32'h0002_3040, 32'h5A58_3040, 1'b1, 0},
        '{1'b0, 32'h0000_1044, 32'h5A5A_1044, 1'b1, 0},
        '{1'b0, 32'h0000_1040, 32'h5A5A_1040, 1'b0, 0},
        '{1'b0, 32'h8000_0F80, 32'hDA5A_0F80, 1'b1, 0},
        '{1'b1, 32'h0000_0000, 32'h0000_0000, 1'b0, 0},
        '{1'b0, 32'h0000_1040, 32'h5A5A_1040, 1'b1, 0},
        '{1'b0, 32'h8000_0F84, 32'hDA5A_0F84, 1'b1, 0},
        '{1'b0, 32'h0000_1050, 32'h5A5A_1050, 1'b0, 3},
        '{1'b0, 32'h0002_3078, 32'h5A58_3078, 1'b1, 2},
        '{1'b0, 32'h8000_0FBC, 32'hDA5A_0FBC, 1'b0, 1}
    };

    l1i_cache dut (
        .clk           (clk),
        .nrst          (nrst),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .req           (req),
        .resp_valid    (resp_valid),
        .resp_ready    (resp_ready),
        .resp          (resp),
        .flush_valid   (flush_valid),
        .flush_ready   (flush_ready),
        .l2_req_valid  (l2_req_valid),
        .l2_req_ready  (l2_req_ready),
        .l2_req        (l2_req),
        .l2_resp_valid (l2_resp_valid),
        .l2_resp_ready (l2_resp_ready),
        .l2_resp       (l2_resp)
    );

    l2_model u_l2_model (
        .clk           (clk),
        .l2_req_valid  (l2_req_valid),
        .l2_req_ready  (l2_req_ready),
        .l2_req        (l2_req),
        .l2_resp_valid (l2_resp_valid),
        .l2_resp_ready (l2_resp_ready),
        .l2_resp       (l2_resp),
        .refill_count  (refill_count)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("SOME TESTS FAILED");
        $fatal(1, "Stopped at the first failing check");
    endtask

    task automatic check_reset_state();
        assert (!resp_valid)
            else report_failure($sformatf("Error: resp_valid = %h after reset, expected 0",
                                          resp_valid));
        assert (!l2_req_valid)
            else report_failure($sformatf("Error: l2_req_valid = %h after reset, expected 0",
                                          l2_req_valid));
        assert (!l2_resp_ready)
            else report_failure($sformatf("Error: l2_resp_ready = %h after reset, expected 0",
                                          l2_resp_ready));
        assert (req_ready)
            else report_failure($sformatf("Error: req_ready = %h after reset, expected 1",
                                          req_ready));
        assert (flush_ready)
            else report_failure($sformatf("Error: flush_ready = %h after reset, expected 1",
                                          flush_ready));
    endtask

    task automatic flush_cache();
        @(posedge clk);
        flush_valid <= 1'b1;
        do
        begin
            @(posedge clk);
        end
        while (!flush_ready);
        flush_valid <= 1'b0;
    endtask

    task automatic run_fetch(input step_t s);
        int                   refills_before;
        int                   latency;
        l1i_geom_pkg::addr_t  exp_line;
        exp_line = (s.addr >> l1i_geom_pkg::OFFSET_W) << l1i_geom_pkg::OFFSET_W;
        refills_before = refill_count;
        @(posedge clk);
        req_valid <= 1'b1;
        req.addr  <= s.addr;
        do
        begin
            @(posedge clk);
        end
        while (!req_ready);
        req_valid  <= 1'b0;
        resp_ready <= (s.stall == 0);
        latency = 0;
        do
        begin
            @(posedge clk);
            latency++;
            if (l2_req_valid && l2_req_ready)
            begin
                assert (l2_req.line_addr == exp_line)
                    else report_failure($sformatf("Error: l2_req.line_addr = %h, expected %h",
                                                  l2_req.line_addr, exp_line));
            end
        end
        while (!resp_valid);
        assert (s.exp_refill || latency == 1)
            else report_failure($sformatf("Hit on %h answered after %0d cycles instead of 1",
                                          s.addr, latency));
        // Each stall edge sees the response held and no new fetch accepted.
        for (int k = 0; k < s.stall; k++)
        begin
            assert (resp_valid)
                else report_failure($sformatf("Error: resp_valid = %h during stall, expected 1",
                                              resp_valid));
            assert (!req_ready)
                else report_failure($sformatf("Error: req_ready = %h during stall, expected 0",
                                              req_ready));
            assert (resp.word == s.exp_word)
                else report_failure($sformatf("Error: resp.word = %h during stall, expected %h",
                                              resp.word, s.exp_word));
            if (k == s.stall - 1)
            begin
                resp_ready <= 1'b1;
            end
            @(posedge clk);
        end
        assert (resp_valid)
            else report_failure("Response was withdrawn before the core accepted it");
        assert (resp.word == s.exp_word)
            else report_failure($sformatf("Error: resp.word = %h, expected %h",
                                          resp.word, s.exp_word));
        assert (refill_count - refills_before == (s.exp_refill ? 1 : 0))
            else report_failure($sformatf("Error: refill count step = %h, expected %h",
                                          refill_count - refills_before, s.exp_refill));
    endtask

    initial
    begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            cycle_count++;
        end
        report_failure($sformatf("Run did not finish within %0d cycles", TIMEOUT_CYCLES));
    end

    initial
    begin
        nrst        = 1'b0;
        req_valid   = 1'b0;
        req         = '0;
        resp_ready  = 1'b1;
        flush_valid = 1'b0;
        repeat (3) @(posedge clk);
        nrst <= 1'b1;
        @(posedge clk);
        check_reset_state();
        for (int i = 0; i < NUM_STEPS; i++)
        begin
            if (steps[i].is_flush)
            begin
                flush_cache();
            end
            else
            begin
                run_fetch(steps[i]);
            end
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- verification/l2_model.sv
`timescale 1ns/1ns

module l2_model (
    input  logic                       clk,
    input  logic                       l2_req_valid,
    output logic                       l2_req_ready,
    input  l1i_bus_pkg::refill_req_t   l2_req,
    output logic                       l2_resp_valid,
    input  logic                       l2_resp_ready,
    output l1i_bus_pkg::refill_resp_t  l2_resp,
    output int                         refill_count
);

    // Each word of the image is its own word address mixed with a fixed pattern.
    function automatic l1i_geom_pkg::line_t image_line(input l1i_geom_pkg::addr_t line_addr);
        l1i_geom_pkg::line_t line;
        line = '0;
        for (int i = 0; i < l1i_geom_pkg::LINE_W / l1i_geom_pkg::WORD_W; i++)
        begin
            line[i * l1i_geom_pkg::WORD_W +: l1i_geom_pkg::WORD_W] =
                (line_addr + 4 * i) ^ 32'h5A5A_0000;
        end
        return line;
    endfunction

    initial
    begin
        int unsigned          delay;
        l1i_geom_pkg::line_t  line;
        void'($urandom(22));
        l2_req_ready  = 1'b0;
        l2_resp_valid = 1'b0;
        l2_resp       = '0;
        refill_count  = 0;
        forever
        begin
            @(posedge clk);
            if (l2_req_valid)
            begin
                delay = $urandom % 4;
                repeat (delay) @(posedge clk);
                l2_req_ready <= 1'b1;
                // The cache holds the request, so it transfers on the next edge.
                @(posedge clk);
                l2_req_ready <= 1'b0;
                refill_count <= refill_count + 1;
                line = image_line(l2_req.line_addr);
                delay = 1 + $urandom % 4;
                repeat (delay) @(posedge clk);
                l2_resp_valid <= 1'b1;
                l2_resp.line  <= line;
                do
                begin
                    @(posedge clk);
                end
                while (!l2_resp_ready);
                l2_resp_valid <= 1'b0;
            end
        end
    end

endmodule
